// File: exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

`define XLEN        32              // Data word width
`define REG_ADDR_W  5               // Register number width
`define ALU_OP_W    3               // ALU operation code width

// ALU operation codes
`define ALU_ADD     3'd0            // Also the load/store address
`define ALU_SUB     3'd1
`define ALU_AND     3'd2
`define ALU_OR      3'd3
`define ALU_XOR     3'd4
`define ALU_SLT     3'd5            // Signed compare
`define ALU_SLTU    3'd6            // Unsigned compare
`define ALU_SLL     3'd7            // Shift by low 5 bits of operand 2

`endif

// File: exec_pkg.sv
`include "exec_config.svh"

package exec_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`ALU_OP_W-1:0]   alu_op_t;

    // One instruction as it arrives at EX
    typedef struct packed {
        logic      valid;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     rs1_data;            // Register file value, not yet forwarded
        word_t     rs2_data;
        word_t     imm;
        logic      use_imm;             // Operand 2 from imm
        alu_op_t   op;
        logic      rf_we;
        reg_addr_t waddr;
        logic      ld;                  // Word load, lane b only
        logic      st;                  // Word store, lane b only
    } issue_lane_t;

    // One lane held in the MEM stage
    typedef struct packed {
        logic      valid;
        logic      rf_we;
        reg_addr_t waddr;
        word_t     result;              // ALU result or memory address
        logic      ld;
        logic      st;
        word_t     sdata;               // Store data after forwarding
    } mem_lane_t;

    // Register file write port, also a forwarding source
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_port_t;

    typedef struct packed {
        logic      rvalid;
        logic      wvalid;
        word_t     addr;
        word_t     wdata;
    } mem_req_t;

    typedef struct packed {
        logic      ready;               // Ends the access, rdata valid too
        word_t     rdata;
    } mem_rsp_t;

endpackage

// File: operand_forward.sv
`timescale 1ns/10ps

module operand_forward (
    input  exec_pkg::issue_lane_t issue_a,
    input  exec_pkg::issue_lane_t issue_b,
    input  exec_pkg::mem_lane_t   mem_a,
    input  exec_pkg::mem_lane_t   mem_b,
    input  exec_pkg::wb_port_t    wb_a,
    input  exec_pkg::wb_port_t    wb_b,
    output exec_pkg::word_t       a_op1,
    output exec_pkg::word_t       a_op2,
    output exec_pkg::word_t       b_op1,
    output exec_pkg::word_t       b_op2
);

    // Youngest producer wins, register 0 keeps the issued value
    function automatic exec_pkg::word_t fwd(
        input exec_pkg::reg_addr_t raddr,
        input exec_pkg::word_t     rdata,
        input exec_pkg::mem_lane_t m_a,
        input exec_pkg::mem_lane_t m_b,
        input exec_pkg::wb_port_t  w_a,
        input exec_pkg::wb_port_t  w_b
    );
        exec_pkg::word_t val;
        val = rdata;
        if (raddr != '0) begin
            if (m_b.valid && m_b.rf_we && !m_b.ld && !m_b.st && m_b.waddr == raddr) begin
                val = m_b.result;           // Load data not there yet
            end else if (m_a.valid && m_a.rf_we && m_a.waddr == raddr) begin
                val = m_a.result;
            end else if (w_b.we && w_b.waddr == raddr) begin
                val = w_b.wdata;
            end else if (w_a.we && w_a.waddr == raddr) begin
                val = w_a.wdata;
            end
        end
        return val;
    endfunction

    assign a_op1 = fwd(issue_a.rs1, issue_a.rs1_data, mem_a, mem_b, wb_a, wb_b);
    assign a_op2 = fwd(issue_a.rs2, issue_a.rs2_data, mem_a, mem_b, wb_a, wb_b);
    assign b_op1 = fwd(issue_b.rs1, issue_b.rs1_data, mem_a, mem_b, wb_a, wb_b);
    assign b_op2 = fwd(issue_b.rs2, issue_b.rs2_data, mem_a, mem_b, wb_a, wb_b); // Also store data

endmodule

// File: alu_lane.sv
`timescale 1ns/10ps

`include "exec_config.svh"

module alu_lane (
    input  exec_pkg::issue_lane_t lane,
    input  exec_pkg::word_t       op1,
    input  exec_pkg::word_t       op2_reg,
    output exec_pkg::word_t       result
);

    localparam int SHAMT_W = $clog2(`XLEN);

    exec_pkg::word_t op2;
    exec_pkg::word_t sum;
    exec_pkg::word_t diff;
    logic            lt_s;
    logic            lt_u;

    assign op2  = lane.use_imm ? lane.imm : op2_reg;
    assign sum  = op1 + op2;                     // Address for lane b loads and stores
    assign diff = op1 - op2;
    assign lt_s = $signed(op1) < $signed(op2);
    assign lt_u = op1 < op2;

    always_comb begin
        case (lane.op)
            `ALU_ADD:  result = sum;
            `ALU_SUB:  result = diff;
            `ALU_AND:  result = op1 & op2;
            `ALU_OR:   result = op1 | op2;
            `ALU_XOR:  result = op1 ^ op2;
            `ALU_SLT:  result = {{(`XLEN-1){1'b0}}, lt_s};
            `ALU_SLTU: result = {{(`XLEN-1){1'b0}}, lt_u};
            `ALU_SLL:  result = op1 << op2[SHAMT_W-1:0];
            default:   result = sum;
        endcase
    end

endmodule

// File: mem_stage.sv
`timescale 1ns/10ps

module mem_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  exec_pkg::issue_lane_t issue_a,
    input  exec_pkg::issue_lane_t issue_b,
    input  exec_pkg::word_t       result_a,
    input  exec_pkg::word_t       result_b,
    input  exec_pkg::word_t       store_data,
    input  exec_pkg::mem_rsp_t    mem_rsp,
    output exec_pkg::mem_lane_t   mem_a,
    output exec_pkg::mem_lane_t   mem_b,
    output exec_pkg::mem_req_t    mem_req,
    output logic                  stall
);

    exec_pkg::mem_lane_t next_a;
    exec_pkg::mem_lane_t next_b;

    function automatic exec_pkg::mem_lane_t to_mem(
        input exec_pkg::issue_lane_t lane,
        input exec_pkg::word_t       result,
        input exec_pkg::word_t       sdata
    );
        exec_pkg::mem_lane_t m;
        m.valid  = lane.valid;
        m.rf_we  = lane.rf_we;
        m.waddr  = lane.waddr;
        m.result = result;
        m.ld     = lane.ld;
        m.st     = lane.st;
        m.sdata  = sdata;
        return m;
    endfunction

    assign next_a = to_mem(issue_a, result_a, '0);          // Lane a never stores
    assign next_b = to_mem(issue_b, result_b, store_data);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_a <= '0;
            mem_b <= '0;
        end else if (!stall) begin                          // Hold both lanes under stall
            mem_a <= next_a;
            mem_b <= next_b;
        end
    end

    // Request comes straight from MEM lane b
    always_comb begin
        mem_req.rvalid = mem_b.valid & mem_b.ld;
        mem_req.wvalid = mem_b.valid & mem_b.st;
        mem_req.addr   = mem_b.result;
        mem_req.wdata  = mem_b.sdata;
    end

    assign stall = (mem_req.rvalid | mem_req.wvalid) & ~mem_rsp.ready;

    a_lane_no_mem: assert property (
        @(posedge clk) disable iff (!arst_n)
        issue_a.valid && !stall |-> !(issue_a.ld || issue_a.st)
    ) else $error("Memory access issued on lane a");

    req_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        stall |=> $stable(mem_req)
    ) else $error("Memory request changed while waiting for ready");

endmodule

// File: wb_stage.sv
`timescale 1ns/10ps

module wb_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  exec_pkg::mem_lane_t mem_a,
    input  exec_pkg::mem_lane_t mem_b,
    input  exec_pkg::word_t     rdata,
    input  logic                stall,
    output exec_pkg::wb_port_t  wb_a,
    output exec_pkg::wb_port_t  wb_b
);

    exec_pkg::wb_port_t next_a;
    exec_pkg::wb_port_t next_b;

    always_comb begin
        next_a.we    = mem_a.valid & mem_a.rf_we;
        next_a.waddr = mem_a.waddr;
        next_a.wdata = mem_a.result;

        next_b.we    = mem_b.valid & mem_b.rf_we & ~mem_b.st;   // Stores write nothing
        next_b.waddr = mem_b.waddr;
        next_b.wdata = mem_b.ld ? rdata : mem_b.result;         // rdata good in the ready cycle
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_a <= '0;
            wb_b <= '0;
        end else if (stall) begin
            wb_a <= '0;                                         // Bubble
            wb_b <= '0;
        end else begin
            wb_a <= next_a;
            wb_b <= next_b;
        end
    end

    // MEM is held under stall, so a write here would be a duplicate
    no_wb_after_stall: assert property (
        @(posedge clk) disable iff (!arst_n)
        stall |=> !(wb_a.we || wb_b.we)
    ) else $error("Write-back after a stalled edge");

endmodule

// File: exec_top.sv
`timescale 1ns/10ps

module exec_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  exec_pkg::issue_lane_t issue_a,      // Older instruction
    input  exec_pkg::issue_lane_t issue_b,      // Younger, may load or store
    input  exec_pkg::mem_rsp_t    mem_rsp,
    output logic                  stall,
    output exec_pkg::mem_req_t    mem_req,
    output exec_pkg::wb_port_t    wb_a,
    output exec_pkg::wb_port_t    wb_b
);

    exec_pkg::mem_lane_t mem_a;
    exec_pkg::mem_lane_t mem_b;
    exec_pkg::word_t     a_op1;
    exec_pkg::word_t     a_op2;
    exec_pkg::word_t     b_op1;
    exec_pkg::word_t     b_op2;
    exec_pkg::word_t     result_a;
    exec_pkg::word_t     result_b;

    operand_forward u_fwd (
        .issue_a (issue_a),
        .issue_b (issue_b),
        .mem_a   (mem_a),
        .mem_b   (mem_b),
        .wb_a    (wb_a),
        .wb_b    (wb_b),
        .a_op1   (a_op1),
        .a_op2   (a_op2),
        .b_op1   (b_op1),
        .b_op2   (b_op2)
    );

    alu_lane u_alu_a (
        .lane    (issue_a),
        .op1     (a_op1),
        .op2_reg (a_op2),
        .result  (result_a)
    );

    alu_lane u_alu_b (
        .lane    (issue_b),
        .op1     (b_op1),
        .op2_reg (b_op2),
        .result  (result_b)
    );

    mem_stage u_mem (
        .clk        (clk),
        .arst_n     (arst_n),
        .issue_a    (issue_a),
        .issue_b    (issue_b),
        .result_a   (result_a),
        .result_b   (result_b),
        .store_data (b_op2),                    // Forwarded rs2 of lane b
        .mem_rsp    (mem_rsp),
        .mem_a      (mem_a),
        .mem_b      (mem_b),
        .mem_req    (mem_req),
        .stall      (stall)
    );

    wb_stage u_wb (
        .clk    (clk),
        .arst_n (arst_n),
        .mem_a  (mem_a),
        .mem_b  (mem_b),
        .rdata  (mem_rsp.rdata),
        .stall  (stall),
        .wb_a   (wb_a),
        .wb_b   (wb_b)
    );

endmodule

// File: tb_exec_top.sv
`timescale 1ns/10ps

`include "exec_config.svh"

module tb_exec_top;

    localparam int NUM_PKT   = 400;
    localparam int MAX_CYCLE = NUM_PKT * 6 + 100;

    typedef struct packed {
        logic                lane_b;
        exec_pkg::reg_addr_t waddr;
        exec_pkg::word_t     wdata;
    } exp_wr_t;

    logic                  clk;
    logic                  arst_n;
    exec_pkg::issue_lane_t issue_a;
    exec_pkg::issue_lane_t issue_b;
    exec_pkg::mem_rsp_t    mem_rsp;
    logic                  stall;
    exec_pkg::mem_req_t    mem_req;
    exec_pkg::wb_port_t    wb_a;
    exec_pkg::wb_port_t    wb_b;

    exec_pkg::word_t     rf [32];           // Fed by the DUT write ports, read at issue
    exec_pkg::word_t     ref_rf [32];
    exec_pkg::word_t     mem_model [64];
    exec_pkg::word_t     ref_mem [64];
    exp_wr_t             exp_q [$];
    exec_pkg::mem_req_t  held_req;
    exec_pkg::reg_addr_t ld_dest;           // Load target of the previous packet, 0 if none
    int                  err_val;
    int                  err_proto;
    int                  n_sent;
    int                  cycles;
    int                  wait_left;
    logic                req_live;
    logic                accepted;
    logic                was_stalled;
    logic                done_issuing;

    exec_top i_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .issue_a (issue_a),
        .issue_b (issue_b),
        .mem_rsp (mem_rsp),
        .stall   (stall),
        .mem_req (mem_req),
        .wb_a    (wb_a),
        .wb_b    (wb_b)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLE) begin
            $display("Timeout after %0d cycles, %0d packets sent, %0d writes still pending",
                     cycles, n_sent, exp_q.size());
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic exec_pkg::word_t exp_alu(input exec_pkg::alu_op_t op,
                                                input exec_pkg::word_t a, input exec_pkg::word_t b);
        case (op)
            `ALU_ADD:  return a + b;
            `ALU_SUB:  return a - b;
            `ALU_AND:  return a & b;
            `ALU_OR:   return a | b;
            `ALU_XOR:  return a ^ b;
            `ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:   return a << b[4:0];
        endcase
    endfunction

    // Source register in 0..7 that keeps clear of two forbidden targets
    function automatic exec_pkg::reg_addr_t pick_src(input exec_pkg::reg_addr_t avoid_x,
                                                     input exec_pkg::reg_addr_t avoid_y);
        exec_pkg::reg_addr_t r;
        r = exec_pkg::reg_addr_t'($urandom % 8);
        while (r != '0 && (r == avoid_x || r == avoid_y)) r = exec_pkg::reg_addr_t'($urandom % 8);
        return r;
    endfunction

    task automatic make_lane(output exec_pkg::issue_lane_t l, input logic is_b,
                             input exec_pkg::reg_addr_t avoid);
        int              kind;
        int              idx;
        exec_pkg::word_t res;
        l         = '0;
        kind      = is_b ? int'($urandom % 4) : 0;              // 2 is a load, 3 a store
        l.valid   = ($urandom % 16) != 0;
        l.rs1     = pick_src(ld_dest, avoid);
        l.rs2     = pick_src(ld_dest, avoid);
        l.imm     = $urandom;
        l.use_imm = ($urandom % 2) == 1;
        l.op      = exec_pkg::alu_op_t'($urandom % 8);
        l.rf_we   = ($urandom % 8) != 0;
        l.waddr   = exec_pkg::reg_addr_t'(1 + $urandom % 7);
        if (is_b && avoid != '0 && ($urandom % 4) == 0) l.waddr = avoid;   // Lane b must win
        if (kind >= 2) begin
            l.rs1     = '0;
            l.use_imm = 1'b1;
            l.op      = `ALU_ADD;
            l.imm     = exec_pkg::word_t'(($urandom % 64) * 4);
            l.ld      = (kind == 2);
            l.st      = (kind == 3);
            l.rf_we   = l.rf_we | l.ld;
        end
        res = exp_alu(l.op, ref_rf[l.rs1], l.use_imm ? l.imm : ref_rf[l.rs2]);
        idx = int'(res[7:2]);
        if (l.valid && l.st) ref_mem[idx] = ref_rf[l.rs2];
        if (l.ld) res = ref_mem[idx];
        if (l.valid && l.rf_we && !l.st) begin
            exp_q.push_back({is_b, l.waddr, res});
            ref_rf[l.waddr] = res;
        end
    endtask

    task automatic next_packet();
        exec_pkg::reg_addr_t avoid;
        if (n_sent == NUM_PKT) begin
            issue_a.valid = 1'b0;
            issue_b.valid = 1'b0;
            done_issuing  = 1'b1;                               // Last packet went in
        end else begin
            make_lane(issue_a, 1'b0, '0);
            avoid = (issue_a.valid && issue_a.rf_we) ? issue_a.waddr : '0;
            make_lane(issue_b, 1'b1, avoid);
            ld_dest = (issue_b.valid && issue_b.ld) ? issue_b.waddr : '0;
            n_sent  = n_sent + 1;
        end
    endtask

    task automatic check_port(input logic lane_b, input exec_pkg::wb_port_t p);
        exp_wr_t e;
        if (p.we) begin
            assert (exp_q.size() != 0) else begin
                err_proto = err_proto + 1;
                $display("Write to r%0d on lane %0d with no write pending", p.waddr, lane_b);
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                assert (e.lane_b == lane_b && e.waddr == p.waddr && e.wdata == p.wdata) else begin
                    err_val = err_val + 1;
                    $display("[ERROR] %0t: lane %0d wrote r%0d=%h, expected lane %0d r%0d=%h",
                             $time, lane_b, p.waddr, p.wdata, e.lane_b, e.waddr, e.wdata);
                end
            end
            if (p.waddr != '0) rf[p.waddr] = p.wdata;
        end
    endtask

    // Memory of 64 words, answers after 0 to 3 wait cycles
    task automatic mem_respond();
        int idx;
        if (mem_rsp.ready) req_live = 1'b0;                     // Taken at the last edge
        mem_rsp.ready = 1'b0;
        mem_rsp.rdata = $urandom;
        if (mem_req.rvalid || mem_req.wvalid) begin
            if (!req_live) begin
                req_live  = 1'b1;
                wait_left = int'($urandom % 4);
                held_req  = mem_req;
            end
            assert (mem_req == held_req) else begin
                err_proto = err_proto + 1;
                $display("Memory request changed while waiting for ready at %0t ns", $time);
            end
            idx = int'(mem_req.addr[7:2]);
            if (wait_left == 0) begin
                mem_rsp.ready = 1'b1;
                if (mem_req.rvalid) mem_rsp.rdata = mem_model[idx];
                else mem_model[idx] = mem_req.wdata;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    endtask

    task automatic step();
        if (was_stalled) begin
            assert (!wb_a.we && !wb_b.we) else begin
                err_proto = err_proto + 1;
                $display("Write-back appeared after a stalled edge at %0t ns", $time);
            end
        end
        mem_respond();
        if (accepted) next_packet();
        issue_a.rs1_data = rf[issue_a.rs1];                     // Register file read each cycle
        issue_a.rs2_data = rf[issue_a.rs2];
        issue_b.rs1_data = rf[issue_b.rs1];
        issue_b.rs2_data = rf[issue_b.rs2];
        check_port(1'b0, wb_a);                                 // WB writes land after the read
        check_port(1'b1, wb_b);
        #1;
        assert (stall == (req_live && !mem_rsp.ready)) else begin
            err_val = err_val + 1;
            $display("[ERROR] %0t: stall is %b while a request waits %b", $time, stall, req_live);
        end
        accepted    = !stall;
        was_stalled = stall;
    endtask

    initial begin
        void'($urandom(32'h2aeb));
        arst_n  = 1'b0;
        issue_a = '0;
        issue_b = '0;
        mem_rsp = '0;
        {err_val, err_proto, n_sent, cycles, wait_left} = '0;
        {req_live, was_stalled, done_issuing} = '0;
        accepted = 1'b1;
        ld_dest  = '0;
        for (int i = 0; i < 32; i++) begin
            rf[i]     = (i == 0) ? '0 : exec_pkg::word_t'(i) * 32'h0f1e_2d3d;
            ref_rf[i] = rf[i];
        end
        for (int i = 0; i < 64; i++) begin
            mem_model[i] = exec_pkg::word_t'(i) * 32'h9e37_79b9 + 32'h1234_5678;
            ref_mem[i]   = mem_model[i];
        end
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        #1;
        assert (!stall && !mem_req.rvalid && !mem_req.wvalid && !wb_a.we && !wb_b.we) else begin
            err_val = err_val + 1;
            $display("[ERROR] %0t: outputs not idle after reset", $time);
        end
        while (!(done_issuing && exp_q.size() == 0)) begin
            @(negedge clk);
            step();
        end
        repeat (4) begin                                        // Catch late extra writes
            @(negedge clk);
            step();
        end
        for (int i = 0; i < 64; i++) begin                      // Store address and data
            assert (mem_model[i] == ref_mem[i]) else begin
                err_val = err_val + 1;
                $display("[ERROR] %0t: memory word %0d is %h, expected %h",
                         $time, i, mem_model[i], ref_mem[i]);
            end
        end
        $display("Errors: %0d value, %0d protocol over %0d packets", err_val, err_proto, n_sent);
        if (err_val + err_proto == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
exec_pkg.sv
operand_forward.sv
alu_lane.sv
mem_stage.sv
wb_stage.sv
exec_top.sv
tb_exec_top.sv

// File: Makefile
TOOL   = verilator
FLAGS  = --binary --timing --assert --timescale 1ns/10ps -Wno-fatal
TOP    = tb_exec_top
FLIST  = flist.f
OBJDIR = obj_dir
LOG    = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation did not pass, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
